// ==== dv/flash_model.sv ====
`timescale 1ns/1ps

module flash_model #(
  parameter int mem_words = 32
) (
  input  logic        spi_clk,
  input  logic        cs_n,
  input  logic        spi_di,
  input  logic        io_oe,
  input  logic [1:0]  latency,
  output logic [3:0]  spi_io,
  output logic [7:0]  cmd_seen,
  output logic [23:0] addr_seen,
  output int          headers_done,  // reads with command and address complete
  output int          proto_errors
);

  logic [19:0] mem [mem_words];
  int          edge_cnt;   // spi_clk rising edges since cs_n fell
  int          dummies;
  int          nib_idx;

  task automatic load_word(input int addr, input logic [19:0] data);
    mem[addr] = data;
  endtask

  // msb nibble of each word first, reads wrap at the end of memory
  function automatic logic [3:0] nibble_at(input int idx);
    logic [19:0] word;
    word = mem[(idx / 5) % mem_words];
    return word[19 - 4 * (idx % 5) -: 4];
  endfunction

  initial begin
    spi_io       = 4'h0;
    cmd_seen     = '0;
    addr_seen    = '0;
    headers_done = 0;
    proto_errors = 0;
    edge_cnt     = 0;
    dummies      = 0;
    nib_idx      = 0;
  end

  always @(negedge cs_n) begin
    edge_cnt  = 0;
    nib_idx   = 0;
    dummies   = 2 * latency;
    cmd_seen  = '0;
    addr_seen = '0;
    spi_io <= 4'hf;  // junk until the dummy clocks are over
  end

  always @(posedge spi_clk) begin
    if (!cs_n) begin
      if (edge_cnt < 8)
        cmd_seen = {cmd_seen[6:0], spi_di};
      else if (edge_cnt < 32)
        addr_seen = {addr_seen[22:0], spi_di};
      else if (edge_cnt >= 32 + dummies)
        nib_idx++;  // host took a nibble
      if (edge_cnt == 31)
        headers_done++;
      edge_cnt++;
    end
  end

  // host drives the lines for command and address only
  always @(negedge spi_clk) begin
    if (!cs_n) begin
      if ((edge_cnt < 32) !== io_oe)
        proto_errors++;
      if (edge_cnt >= 32 + dummies)
        spi_io <= nibble_at(nib_idx);
    end
  end

endmodule

// ==== dv/tb_flash_video.sv ====
`timescale 1ns/1ps

module tb_flash_video
  import video_pkg::*;
();

  localparam int h_active   = 24;
  localparam int v_active   = 4;
  localparam int n_pix      = h_active * v_active;
  localparam int n_entries  = 9;
  localparam int mem_words  = 32;
  localparam int wait_limit = 2000;

  // things a wait can be for
  localparam int w_de      = 0;
  localparam int w_header  = 1;
  localparam int w_cs_rise = 2;

  logic        clk;
  logic        reset;
  logic [1:0]  spi_latency;
  logic [3:0]  spi_io;
  logic        spi_clk;
  logic        cs_n;
  logic        spi_di;
  logic        io_oe;
  logic        hsync;
  logic        vsync;
  logic        de;
  logic [8:0]  colour_out;
  logic [7:0]  cmd_seen;
  logic [23:0] addr_seen;
  int          headers_done;
  int          proto_errors;

  // instruction table
  logic [1:0]  tab_op  [n_entries];
  int          tab_len [n_entries];
  logic [8:0]  tab_col [n_entries];
  logic [8:0]  exp_pix [n_pix];
  bit          exp_eol [n_pix];   // pixel blanked by an end-of-line

  integer      seed;
  int          test_errs [1:7];
  int          tests_failed;
  int          hs_active_cnt;
  int          vs_cnt;
  int          cs_rise_cnt;
  int          frame_hs;    // sync counts at the first pixel of the last frame
  int          frame_vs;
  bit          have_frame;
  bit          line_had_de;
  logic        hs_prev;
  logic        vs_prev;
  logic        cs_prev;
  bit          timed_out;

  always #4 clk = ~clk;

  flash_video_top #(
    .h_active    (h_active),
    .h_front     (4),
    .h_sync      (4),
    .h_back      (8),
    .v_active    (v_active),
    .v_front     (1),
    .v_sync      (1),
    .v_back      (2),
    .queue_depth (3)
  ) u_flash_video_top (
    .clk         (clk),
    .reset       (reset),
    .spi_latency (spi_latency),
    .spi_io_in   (spi_io),
    .spi_clk     (spi_clk),
    .cs_n        (cs_n),
    .spi_di      (spi_di),
    .io_oe       (io_oe),
    .hsync       (hsync),
    .vsync       (vsync),
    .de          (de),
    .colour_out  (colour_out)
  );

  flash_model #(
    .mem_words (mem_words)
  ) u_flash_model (
    .spi_clk      (spi_clk),
    .cs_n         (cs_n),
    .spi_di       (spi_di),
    .io_oe        (io_oe),
    .latency      (spi_latency),
    .spi_io       (spi_io),
    .cmd_seen     (cmd_seen),
    .addr_seen    (addr_seen),
    .headers_done (headers_done),
    .proto_errors (proto_errors)
  );

  task automatic report_mismatch(input int test_no, input string sig,
                                 input logic [31:0] exp_val, input logic [31:0] act_val);
    $display("mismatch at %0t ns: %s expected %0h got %0h", $time, sig, exp_val, act_val);
    test_errs[test_no]++;
  endtask

  task automatic set_entry(input int i, input logic [1:0] op, input int len);
    tab_op[i]  = op;
    tab_len[i] = len;
    tab_col[i] = 9'($random(seed));
  endtask

  // 24 pixel lines, runs may wrap into the next line
  task automatic build_table();
    set_entry(0, op_run, 12);
    set_entry(1, op_run, 20);   // wraps into line 1
    set_entry(2, op_run, 12);
    set_entry(3, op_eol, 1);
    set_entry(4, op_run, 14);
    set_entry(5, op_eol, 1);
    set_entry(6, op_run, 12);
    set_entry(7, op_run, 12);
    set_entry(8, op_eof, 1);
  endtask

  task automatic build_expected();
    int pos;
    int e;
    int k;
    pos = 0;
    for (k = 0; k < n_pix; k++) begin
      exp_pix[k] = '0;
      exp_eol[k] = 1'b0;
    end
    for (e = 0; e < n_entries && pos < n_pix; e++) begin
      if (tab_op[e] == op_eof) begin
        pos = n_pix;  // black for the rest of the frame
      end else if (tab_op[e] == op_eol) begin
        while (pos % h_active != 0) begin
          exp_eol[pos] = 1'b1;
          pos++;
        end
      end else begin
        for (k = 0; k < tab_len[e] && pos < n_pix; k++) begin
          exp_pix[pos] = tab_col[e];
          pos++;
        end
      end
    end
  endtask

  // opcode, colour, count minus one
  task automatic load_flash();
    int i;
    logic [19:0] w;
    for (i = 0; i < mem_words; i++) begin
      if (i < n_entries)
        w = {tab_op[i], tab_col[i], 9'(tab_len[i] - 1)};
      else
        w = 20'h3c3c3 ^ 20'(i * 20'h0a3c5);
      u_flash_model.load_word(i, w);
    end
  endtask

  function automatic bit cond_met(input int cond, input int target);
    case (cond)
      w_de:     return de === 1'b1;
      w_header: return headers_done >= target;
      default:  return cs_rise_cnt >= target;
    endcase
  endfunction

  task automatic wait_until(input int cond, input int target, input string what);
    int n;
    n = 0;
    while (!cond_met(cond, target) && n < wait_limit && !timed_out) begin
      @(negedge clk);
      n++;
    end
    if (!cond_met(cond, target) && !timed_out) begin
      $display("timeout: %s did not happen within %0d cycles", what, wait_limit);
      timed_out = 1'b1;
    end
  endtask

  task automatic end_test(input int test_no, input string name);
    if (test_errs[test_no] == 0) begin
      $display("test %0d %s: pass", test_no, name);
    end else begin
      $display("test %0d %s: fail, %0d errors", test_no, name, test_errs[test_no]);
      tests_failed++;
    end
  endtask

  task automatic check_idle_outputs();
    if (cs_n !== 1'b1) report_mismatch(1, "cs_n", 1, cs_n);
    if (hsync !== 1'b1) report_mismatch(1, "hsync", 1, hsync);
    if (vsync !== 1'b1) report_mismatch(1, "vsync", 1, vsync);
    if (de !== 1'b0) report_mismatch(1, "de", 0, de);
    if (colour_out !== 9'd0) report_mismatch(1, "colour_out", 0, colour_out);
  endtask

  task automatic check_header(input int test_no, input int read_no);
    wait_until(w_header, read_no, "flash read command and address");
    if (timed_out)
      return;
    if (cmd_seen !== 8'h6b) report_mismatch(test_no, "flash command", 8'h6b, cmd_seen);
    if (addr_seen !== 24'h0) report_mismatch(test_no, "flash address", 0, addr_seen);
    if (proto_errors != 0) begin
      $display("flash model saw io_oe in the wrong state on %0d clock edges", proto_errors);
      test_errs[test_no]++;
    end
  endtask

  // first pixel to first pixel spans one frame period
  task automatic check_frame_syncs();
    if (have_frame) begin
      if (hs_active_cnt - frame_hs != v_active)
        report_mismatch(7, "hsync pulses in active lines", v_active, hs_active_cnt - frame_hs);
      if (vs_cnt - frame_vs != 1) report_mismatch(7, "vsync pulses", 1, vs_cnt - frame_vs);
    end
    frame_hs   = hs_active_cnt;
    frame_vs   = vs_cnt;
    have_frame = 1'b1;
  endtask

  task automatic check_frame(input int run_test, input int eol_test);
    int line;
    int x;
    int idx;
    int tst;
    for (line = 0; line < v_active; line++) begin
      wait_until(w_de, 0, "display enable of an active line");
      if (timed_out)
        return;
      if (line == 0)
        check_frame_syncs();
      for (x = 0; x < h_active; x++) begin
        idx = line * h_active + x;
        tst = exp_eol[idx] ? eol_test : run_test;
        if (de !== 1'b1) report_mismatch(tst, "de", 1, de);
        if (colour_out !== exp_pix[idx]) report_mismatch(tst, "colour_out", exp_pix[idx], colour_out);
        @(negedge clk);
      end
      if (de !== 1'b0) report_mismatch(7, "de after line", 0, de);
    end
  endtask

  // sampled on the rising edge, before the registers move
  always @(posedge clk) begin
    if (!reset) begin
      if (!de && colour_out !== 9'd0)
        report_mismatch(7, "colour_out while de low", 0, colour_out);
      if (de)
        line_had_de = 1'b1;
      if (!hsync && hs_prev) begin
        if (line_had_de)
          hs_active_cnt++;
        line_had_de = 1'b0;
      end
      if (!vsync && vs_prev) vs_cnt++;
      if (cs_n && !cs_prev) cs_rise_cnt++;
    end
    hs_prev = hsync;
    vs_prev = vsync;
    cs_prev = cs_n;
  end

  initial begin
    int i;
    int total_errs;
    clk           = 1'b0;
    reset         = 1'b1;
    spi_latency   = 2'd1;
    seed          = 32'hcb5c98ae;
    timed_out     = 1'b0;
    tests_failed  = 0;
    hs_active_cnt = 0;
    vs_cnt        = 0;
    cs_rise_cnt   = 0;
    frame_hs      = 0;
    frame_vs      = 0;
    have_frame    = 1'b0;
    line_had_de   = 1'b0;
    hs_prev       = 1'b1;
    vs_prev       = 1'b1;
    cs_prev       = 1'b1;
    for (i = 1; i <= 7; i++)
      test_errs[i] = 0;
    build_table();
    build_expected();
    load_flash();

    repeat (5) @(posedge clk);
    @(negedge clk);
    check_idle_outputs();
    reset = 1'b0;
    @(negedge clk);
    check_idle_outputs();   // first cycle out of reset
    end_test(1, "reset outputs");

    check_header(2, 1);
    spi_latency = 2'd3;     // read one already latched its latency
    if (!timed_out) end_test(2, "read start, latency 1");
    if (!timed_out) check_frame(3, 4);
    if (!timed_out) end_test(3, "frame one run pixels");
    if (!timed_out) end_test(4, "frame one end-of-line blanking");
    if (!timed_out) wait_until(w_cs_rise, 1, "cs_n rise after end of frame");
    if (!timed_out) check_header(5, 2);
    if (!timed_out) end_test(5, "restart and read start, latency 3");
    if (!timed_out) check_frame(6, 6);
    if (!timed_out) end_test(6, "frame two pixel map");
    if (!timed_out) wait_until(w_de, 0, "display enable of the frame after frame two");
    if (!timed_out) check_frame_syncs();
    if (!timed_out) end_test(7, "blank colour and sync counts");

    total_errs = 0;
    for (i = 1; i <= 7; i++)
      total_errs += test_errs[i];
    $display("tests failed %0d, mismatches %0d, timeout %0d", tests_failed, total_errs,
             timed_out);
    if (timed_out || total_errs != 0) begin
      $display("CHECKS FAILED");
    end else begin
      $display("ALL CHECKS PASSED");
    end
    $finish;
  end

endmodule

// ==== logic/display_if.sv ====
`timescale 1ns/1ps

interface display_if
  import video_pkg::*;
();

  logic    pixel_req;   // next clock shows an active pixel
  logic    next_line;   // pulse at the last active pixel of a line
  logic    next_frame;  // pulse at the start of vertical blanking
  colour_t colour;

  modport decoder (input pixel_req, input next_line, input next_frame, output colour);

  modport timing (output pixel_req, output next_line, output next_frame, input colour);

endinterface

// ==== logic/flash_video_top.sv ====
`timescale 1ns/1ps

module flash_video_top
  import video_pkg::*;
#(
  parameter int h_active    = 640,
  parameter int h_front     = 16,
  parameter int h_sync      = 96,
  parameter int h_back      = 48,
  parameter int v_active    = 480,
  parameter int v_front     = 10,
  parameter int v_sync      = 2,
  parameter int v_back      = 33,
  parameter int queue_depth = 3
) (
  input  logic       clk,
  input  logic       reset,
  input  logic [1:0] spi_latency,
  input  logic [3:0] spi_io_in,
  output logic       spi_clk,
  output logic       cs_n,
  output logic       spi_di,
  output logic       io_oe,
  output logic       hsync,
  output logic       vsync,
  output logic       de,
  output colour_t    colour_out
);

  logic              restart;
  logic              queue_full;
  logic              queue_empty;
  logic              pop;
  logic              word_valid;
  logic [word_w-1:0] word_data;
  logic [word_w-1:0] queue_head;

  display_if disp_bus ();

  qspi_reader u_qspi_reader (
    .clk         (clk),
    .reset       (reset),
    .restart     (restart),
    .spi_latency (spi_latency),
    .queue_full  (queue_full),
    .spi_clk     (spi_clk),
    .cs_n        (cs_n),
    .spi_di      (spi_di),
    .spi_io_in   (spi_io_in),
    .io_oe       (io_oe),
    .word_valid  (word_valid),
    .word_data   (word_data)
  );

  prefetch_queue #(
    .queue_depth (queue_depth)
  ) u_prefetch_queue (
    .clk         (clk),
    .reset       (reset),
    .flush       (restart),
    .push        (word_valid),
    .push_data   (word_data),
    .pop         (pop),
    .head        (queue_head),
    .queue_empty (queue_empty),
    .queue_full  (queue_full)
  );

  instr_decoder u_instr_decoder (
    .clk         (clk),
    .reset       (reset),
    .head        (queue_head),
    .queue_empty (queue_empty),
    .pop         (pop),
    .restart     (restart),
    .disp        (disp_bus)
  );

  vga_timing #(
    .h_active (h_active),
    .h_front  (h_front),
    .h_sync   (h_sync),
    .h_back   (h_back),
    .v_active (v_active),
    .v_front  (v_front),
    .v_sync   (v_sync),
    .v_back   (v_back)
  ) u_vga_timing (
    .clk        (clk),
    .reset      (reset),
    .disp       (disp_bus),
    .hsync      (hsync),
    .vsync      (vsync),
    .de         (de),
    .colour_out (colour_out)
  );

endmodule

// ==== logic/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder
  import video_pkg::*;
(
  input  logic               clk,
  input  logic               reset,
  input  instr_t             head,
  input  logic               queue_empty,
  output logic               pop,
  output logic               restart,
  display_if.decoder         disp
);

  typedef enum logic [1:0] {
    s_load,   // waiting for a word
    s_run,    // emitting cur_colour
    s_line,   // black until next_line
    s_frame   // black until next_frame
  } dec_state_t;

  dec_state_t state;
  colour_t    cur_colour;
  logic [8:0] remaining;   // pixels left in the run, minus one
  logic       need_word;
  logic       run_done;

  assign run_done  = (state == s_run) && disp.pixel_req && (remaining == 9'd0);
  assign need_word = (state == s_load) || run_done;
  assign pop       = need_word && !queue_empty;

  // same cycle as the queue flush, so nothing stale gets popped
  assign restart = (state == s_frame) && disp.next_frame;

  assign disp.colour = (state == s_run) ? cur_colour : '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= s_frame;  // first next_frame starts the first read
    end else begin
      case (state)
        s_line:  if (disp.next_line) state <= s_load;
        s_frame: if (disp.next_frame) state <= s_load;
        default: ;
      endcase
      if (need_word) begin
        if (queue_empty) begin
          state <= s_load;  // underrun shows black
        end else begin
          case (head.opcode)
            // a line that ended exactly on this pixel needs no wait
            op_eol:  state <= disp.next_line ? s_load : s_line;
            op_eof:  state <= s_frame;
            default: state <= s_run;
          endcase
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pop && (head.opcode != op_eol) && (head.opcode != op_eof)) begin
      cur_colour <= head.colour;
      remaining  <= head.count;
    end else if ((state == s_run) && disp.pixel_req && (remaining != 9'd0)) begin
      remaining <= remaining - 9'd1;
    end
  end

endmodule

// ==== logic/prefetch_queue.sv ====
`timescale 1ns/1ps

module prefetch_queue
  import video_pkg::*;
#(
  parameter int queue_depth = 3
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              flush,
  input  logic              push,
  input  logic [word_w-1:0] push_data,
  input  logic              pop,
  output logic [word_w-1:0] head,
  output logic              queue_empty,
  output logic              queue_full
);

  localparam int ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;
  localparam int cnt_w = $clog2(queue_depth + 1);

  logic [word_w-1:0] mem [queue_depth];
  logic [ptr_w-1:0]  rd_ptr;
  logic [ptr_w-1:0]  wr_ptr;
  logic [cnt_w-1:0]  count;
  logic              do_push;
  logic              do_pop;

  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    return (ptr == ptr_w'(queue_depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign do_push = push && !queue_full;
  assign do_pop  = pop && !queue_empty;

  assign queue_empty = (count == '0);
  assign queue_full  = (count == cnt_w'(queue_depth));
  assign head        = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push)
        wr_ptr <= next_ptr(wr_ptr);
      if (do_pop)
        rd_ptr <= next_ptr(rd_ptr);
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (do_push)
      mem[wr_ptr] <= push_data;
  end

endmodule

// ==== logic/qspi_reader.sv ====
`timescale 1ns/1ps

module qspi_reader
  import video_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              restart,
  input  logic [1:0]        spi_latency,
  input  logic              queue_full,
  output logic              spi_clk,
  output logic              cs_n,
  output logic              spi_di,
  input  logic [3:0]        spi_io_in,
  output logic              io_oe,
  output logic              word_valid,
  output logic [word_w-1:0] word_data
);

  typedef enum logic [2:0] {
    st_idle,
    st_cmd,
    st_addr,
    st_dummy,
    st_data
  } phase_t;

  phase_t            state;
  logic              start_req;   // read requested, cs_n already high
  logic [1:0]        latency;     // sampled at read start
  logic [4:0]        bit_cnt;     // rising edges within the phase
  logic [2:0]        nib_cnt;
  logic [4:0]        dummy_last;
  logic              stall;
  logic              sample;
  logic [word_w-1:0] shift_reg;

  assign dummy_last = {2'b00, latency, 1'b0} - 5'd1;

  // hold spi_clk low before a rising edge while the queue has no room
  assign stall  = (state == st_data) && !spi_clk && queue_full;
  assign sample = (state == st_data) && !spi_clk && !stall;

  assign word_data = shift_reg;

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= st_idle;
      start_req  <= 1'b0;
      cs_n       <= 1'b1;
      spi_clk    <= 1'b0;
      spi_di     <= 1'b0;
      io_oe      <= 1'b0;
      word_valid <= 1'b0;
      latency    <= 2'd0;
      bit_cnt    <= 5'd0;
      nib_cnt    <= 3'd0;
    end else if (restart) begin
      // abort whatever is in flight, deselect for at least a clock
      state      <= st_idle;
      start_req  <= 1'b1;
      cs_n       <= 1'b1;
      spi_clk    <= 1'b0;
      spi_di     <= 1'b0;
      io_oe      <= 1'b0;
      word_valid <= 1'b0;
    end else begin
      word_valid <= 1'b0;
      if (state == st_idle) begin
        if (start_req) begin
          start_req <= 1'b0;
          cs_n      <= 1'b0;
          io_oe     <= 1'b1;
          latency   <= spi_latency;
          spi_di    <= read_cmd[7];  // msb first
          bit_cnt   <= 5'd0;
          nib_cnt   <= 3'd0;
          state     <= st_cmd;
        end
      end else begin
        if (!stall)
          spi_clk <= ~spi_clk;
        if (spi_clk) begin
          // falling edge, set up the next serial bit (address is all zero)
          spi_di <= (state == st_cmd) ? read_cmd[~bit_cnt[2:0]] : 1'b0;
        end else if (!stall) begin
          bit_cnt <= bit_cnt + 5'd1;
          case (state)
            st_cmd: begin
              if (bit_cnt == 5'd7) begin
                bit_cnt <= 5'd0;
                state   <= st_addr;
              end
            end
            st_addr: begin
              if (bit_cnt == 5'd23) begin
                bit_cnt <= 5'd0;
                io_oe   <= 1'b0;     // flash owns the lines from here
                state   <= (latency == 2'd0) ? st_data : st_dummy;
              end
            end
            st_dummy: begin
              if (bit_cnt == dummy_last) begin
                bit_cnt <= 5'd0;
                state   <= st_data;
              end
            end
            default: begin
              bit_cnt <= 5'd0;
              if (nib_cnt == 3'(nibbles_per_word - 1)) begin
                nib_cnt    <= 3'd0;
                word_valid <= 1'b1;  // shift_reg holds the full word next cycle
              end else begin
                nib_cnt <= nib_cnt + 3'd1;
              end
            end
          endcase
        end
      end
    end
  end

  // msb nibble first
  always_ff @(posedge clk) begin
    if (sample)
      shift_reg <= {shift_reg[word_w-5:0], spi_io_in};
  end

endmodule

// ==== logic/vga_timing.sv ====
`timescale 1ns/1ps

module vga_timing
  import video_pkg::*;
#(
  parameter int h_active = 640,
  parameter int h_front  = 16,
  parameter int h_sync   = 96,
  parameter int h_back   = 48,
  parameter int v_active = 480,
  parameter int v_front  = 10,
  parameter int v_sync   = 2,
  parameter int v_back   = 33
) (
  input  logic      clk,
  input  logic      reset,
  display_if.timing disp,
  output logic      hsync,
  output logic      vsync,
  output logic      de,
  output colour_t   colour_out
);

  localparam int h_total = h_active + h_front + h_sync + h_back;
  localparam int v_total = v_active + v_front + v_sync + v_back;
  localparam int hc_w    = $clog2(h_total);
  localparam int vc_w    = $clog2(v_total);

  logic [hc_w-1:0] h_cnt;
  logic [vc_w-1:0] v_cnt;
  logic            active;
  logic            hs_pulse;
  logic            vs_pulse;

  assign active   = (h_cnt < hc_w'(h_active)) && (v_cnt < vc_w'(v_active));
  assign hs_pulse = (h_cnt >= hc_w'(h_active + h_front)) &&
                    (h_cnt <  hc_w'(h_active + h_front + h_sync));
  assign vs_pulse = (v_cnt >= vc_w'(v_active + v_front)) &&
                    (v_cnt <  vc_w'(v_active + v_front + v_sync));

  assign disp.pixel_req  = active;
  assign disp.next_line  = (h_cnt == hc_w'(h_active - 1)) && (v_cnt < vc_w'(v_active));
  assign disp.next_frame = (h_cnt == '0) && (v_cnt == vc_w'(v_active));

  always_ff @(posedge clk) begin
    if (reset) begin
      h_cnt      <= '0;
      v_cnt      <= vc_w'(v_active);  // start in vertical blanking
      hsync      <= 1'b1;
      vsync      <= 1'b1;
      de         <= 1'b0;
      colour_out <= '0;
    end else begin
      if (h_cnt == hc_w'(h_total - 1)) begin
        h_cnt <= '0;
        v_cnt <= (v_cnt == vc_w'(v_total - 1)) ? '0 : v_cnt + 1'b1;
      end else begin
        h_cnt <= h_cnt + 1'b1;
      end
      hsync      <= ~hs_pulse;  // active low
      vsync      <= ~vs_pulse;
      de         <= active;
      colour_out <= active ? disp.colour : '0;
    end
  end

endmodule

// ==== logic/video_pkg.sv ====
package video_pkg;

  // one flash word carries one instruction
  localparam int word_w = 20;
  localparam int nibbles_per_word = 5;

  // quad output fast read
  localparam logic [7:0] read_cmd = 8'h6b;

  // rrr_ggg_bbb
  typedef logic [8:0] colour_t;

  typedef enum logic [1:0] {
    op_run  = 2'd0,
    op_eol  = 2'd1,
    op_eof  = 2'd2,
    op_rsvd = 2'd3   // decoded as a run
  } opcode_t;

  // bits 19..18 opcode, 17..9 colour, 8..0 pixel count minus one
  typedef struct packed {
    opcode_t     opcode;
    colour_t     colour;
    logic [8:0]  count;
  } instr_t;

endpackage

// ==== verilog.f ====
logic/video_pkg.sv
logic/display_if.sv
logic/qspi_reader.sv
logic/prefetch_queue.sv
logic/instr_decoder.sv
logic/vga_timing.sv
logic/flash_video_top.sv
dv/flash_model.sv
dv/tb_flash_video.sv
